//--- common/pdp_exec_pkg.sv
// shared types for the execute stage
// machine word, condition codes, decoded class and queue entries
// octal opcode fields for the supported instruction set
package pdp_exec_pkg;

   localparam int isn_width = 16;

   typedef logic [isn_width-1:0] word_t;

   // n z v c, n in the top bit
   typedef logic [3:0] cc_t;

   localparam int cc_n_bit = 3;
   localparam int cc_z_bit = 2;
   localparam int cc_v_bit = 1;
   localparam int cc_c_bit = 0;

   typedef enum logic [2:0] {
      op_dual,
      op_single,
      op_branch,
      op_ccop,
      op_none
   } op_class_t;

   typedef struct packed {
      word_t isn;
      word_t pc;
      word_t ss_data;
      word_t dd_data;
   } isn_entry_t;

   typedef struct packed {
      word_t result;
      word_t new_pc;
      logic  latch_pc;
      cc_t   new_cc;
      logic  latch_cc;
   } res_entry_t;

   // double operand, isn[15:12]
   localparam logic [3:0] opc_mov = 4'o01;
   localparam logic [3:0] opc_cmp = 4'o02;
   localparam logic [3:0] opc_bit = 4'o03;
   localparam logic [3:0] opc_bic = 4'o04;
   localparam logic [3:0] opc_bis = 4'o05;
   localparam logic [3:0] opc_add = 4'o06;
   localparam logic [3:0] opc_sub = 4'o16;
   // register form, isn[15:9]
   localparam logic [6:0] opc_xor = 7'o074;

   // single operand, isn[15:6]
   localparam logic [9:0] sop_clr = 10'o0050;
   localparam logic [9:0] sop_com = 10'o0051;
   localparam logic [9:0] sop_inc = 10'o0052;
   localparam logic [9:0] sop_dec = 10'o0053;
   localparam logic [9:0] sop_neg = 10'o0054;
   localparam logic [9:0] sop_tst = 10'o0057;
   localparam logic [9:0] sop_ror = 10'o0060;
   localparam logic [9:0] sop_rol = 10'o0061;
   localparam logic [9:0] sop_asr = 10'o0062;
   localparam logic [9:0] sop_asl = 10'o0063;

   // 000240 to 000277, isn[15:5]
   localparam logic [10:0] ccop_prefix = 11'o0005;

   // branches, isn[15:8]
   localparam logic [7:0] br_br  = 8'o001;
   localparam logic [7:0] br_bne = 8'o002;
   localparam logic [7:0] br_beq = 8'o003;
   localparam logic [7:0] br_bpl = 8'o200;
   localparam logic [7:0] br_bmi = 8'o201;
   localparam logic [7:0] br_bcc = 8'o206;
   localparam logic [7:0] br_bcs = 8'o207;

endpackage

//--- logic/credit_fifo.sv
// synchronous circular FIFO with a typed payload
// occupancy count drives valid and full
module credit_fifo #(
   parameter int  depth     = 4,
   parameter type payload_t = logic [15:0]
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     push,
   input  payload_t push_data,
   input  logic     pop,
   output payload_t head,
   output logic     fifo_valid,
   output logic     full
);
   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);

   payload_t         mem [depth];
   logic [ptr_w-1:0] rd_ptr;
   logic [ptr_w-1:0] wr_ptr;
   logic [cnt_w-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign do_push    = push && !full;
   assign do_pop     = pop && fifo_valid;
   assign head       = mem[rd_ptr];
   assign fifo_valid = (count != '0);
   assign full       = (count == cnt_w'(depth));

   // storage, written at the tail
   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         // pointers wrap explicitly so any depth works
         if (do_push)
            wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
      end
   end

endmodule

//--- execute/word_alu.sv
// word double and single operand operations
// result and new n/z/v/c per pdp-11 rules
module word_alu import pdp_exec_pkg::*; (
   input  word_t isn,
   input  word_t ss_data,
   input  word_t dd_data,
   input  cc_t   cc,
   output word_t result,
   output cc_t   new_cc
);
   logic [16:0] sum;
   logic        v_flag;
   logic        c_flag;
   logic        known;

   // carry out of the add
   assign sum = {1'b0, ss_data} + {1'b0, dd_data};

   always_comb
   begin
      result = '0;
      v_flag = cc[cc_v_bit];
      c_flag = cc[cc_c_bit];
      known  = 1'b1;
      if (isn[15:9] == opc_xor)
      begin
         result = ss_data ^ dd_data;
         v_flag = 1'b0;
      end
      else
      begin
         case (isn[15:12])
            opc_mov:
            begin
               result = ss_data;
               v_flag = 1'b0;
            end
            opc_cmp:
            begin
               // src minus dst
               result = ss_data - dd_data;
               v_flag = (ss_data[15] ^ dd_data[15]) & ~(dd_data[15] ^ result[15]);
               c_flag = (ss_data < dd_data);
            end
            opc_bit:
            begin
               result = ss_data & dd_data;
               v_flag = 1'b0;
            end
            opc_bic:
            begin
               result = ~ss_data & dd_data;
               v_flag = 1'b0;
            end
            opc_bis:
            begin
               result = ss_data | dd_data;
               v_flag = 1'b0;
            end
            opc_add:
            begin
               result = sum[15:0];
               v_flag = ~(ss_data[15] ^ dd_data[15]) & (ss_data[15] ^ result[15]);
               c_flag = sum[16];
            end
            opc_sub:
            begin
               // dst minus src with borrow into c
               result = dd_data - ss_data;
               v_flag = (ss_data[15] ^ dd_data[15]) & ~(ss_data[15] ^ result[15]);
               c_flag = (dd_data < ss_data);
            end
            default:
            begin
               case (isn[15:6])
                  sop_clr:
                  begin
                     result = '0;
                     v_flag = 1'b0;
                     c_flag = 1'b0;
                  end
                  sop_com:
                  begin
                     result = ~dd_data;
                     v_flag = 1'b0;
                     c_flag = 1'b1;
                  end
                  sop_inc:
                  begin
                     result = dd_data + 16'd1;
                     v_flag = (result == 16'o100000);
                  end
                  sop_dec:
                  begin
                     result = dd_data - 16'd1;
                     v_flag = (result == 16'o077777);
                  end
                  sop_neg:
                  begin
                     result = -dd_data;
                     v_flag = (result == 16'o100000);
                     c_flag = (result != '0);
                  end
                  sop_tst:
                  begin
                     result = dd_data;
                     v_flag = 1'b0;
                     c_flag = 1'b0;
                  end
                  // rotates and shifts set v to n xor c
                  sop_ror:
                  begin
                     result = {cc[cc_c_bit], dd_data[15:1]};
                     c_flag = dd_data[0];
                     v_flag = result[15] ^ dd_data[0];
                  end
                  sop_rol:
                  begin
                     result = {dd_data[14:0], cc[cc_c_bit]};
                     c_flag = dd_data[15];
                     v_flag = result[15] ^ dd_data[15];
                  end
                  sop_asr:
                  begin
                     result = {dd_data[15], dd_data[15:1]};
                     c_flag = dd_data[0];
                     v_flag = result[15] ^ dd_data[0];
                  end
                  sop_asl:
                  begin
                     result = {dd_data[14:0], 1'b0};
                     c_flag = dd_data[15];
                     v_flag = result[15] ^ dd_data[15];
                  end
                  default: known = 1'b0;
               endcase
            end
         endcase
      end

      new_cc = cc;
      if (known)
      begin
         new_cc[cc_n_bit] = result[15];
         new_cc[cc_z_bit] = (result == '0);
         new_cc[cc_v_bit] = v_flag;
         new_cc[cc_c_bit] = c_flag;
      end
   end

endmodule

//--- execute/branch_unit.sv
// branch target and condition test
// cc clear/set operand decode
module branch_unit import pdp_exec_pkg::*; (
   input  word_t isn,
   input  word_t pc,
   input  cc_t   cc,
   output word_t new_pc,
   output logic  take,
   output cc_t   ccop_cc
);
   word_t offset;
   cc_t   cc_mask;

   // signed 8-bit word offset, doubled to bytes
   assign offset = {{7{isn[7]}}, isn[7:0], 1'b0};
   assign new_pc = pc + offset;

   always_comb
   begin
      case (isn[15:8])
         br_br:   take = 1'b1;
         br_bne:  take = ~cc[cc_z_bit];
         br_beq:  take = cc[cc_z_bit];
         br_bpl:  take = ~cc[cc_n_bit];
         br_bmi:  take = cc[cc_n_bit];
         br_bcc:  take = ~cc[cc_c_bit];
         br_bcs:  take = cc[cc_c_bit];
         default: take = 1'b0;
      endcase
   end

   // low four bits pick n z v c in cc order
   assign cc_mask = isn[3:0];

   always_comb
   begin
      if (isn[4])
         ccop_cc = cc | cc_mask;
      else
         ccop_cc = cc & ~cc_mask;
   end

endmodule

//--- execute/exec_core.sv
// issue control and opcode class decode
// condition-code register and result entry assembly
module exec_core import pdp_exec_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  isn_entry_t head,
   input  logic       fifo_valid,
   input  logic       can_issue,
   output logic       pop,
   output res_entry_t push_data
);
   op_class_t cls;
   cc_t       cc_q;
   word_t     alu_result;
   cc_t       alu_cc;
   word_t     br_new_pc;
   logic      br_take;
   cc_t       ccop_cc;

   word_alu alu (
      .isn     (head.isn),
      .ss_data (head.ss_data),
      .dd_data (head.dd_data),
      .cc      (cc_q),
      .result  (alu_result),
      .new_cc  (alu_cc)
   );

   branch_unit bru (
      .isn     (head.isn),
      .pc      (head.pc),
      .cc      (cc_q),
      .new_pc  (br_new_pc),
      .take    (br_take),
      .ccop_cc (ccop_cc)
   );

   // the opcode groups are disjoint
   always_comb
   begin
      cls = op_none;
      case (head.isn[15:12])
         opc_mov, opc_cmp, opc_bit, opc_bic, opc_bis, opc_add, opc_sub: cls = op_dual;
         default: ;
      endcase
      if (head.isn[15:9] == opc_xor)
         cls = op_dual;
      case (head.isn[15:6])
         sop_clr, sop_com, sop_inc, sop_dec, sop_neg,
         sop_tst, sop_ror, sop_rol, sop_asr, sop_asl: cls = op_single;
         default: ;
      endcase
      case (head.isn[15:8])
         br_br, br_bne, br_beq, br_bpl, br_bmi, br_bcc, br_bcs: cls = op_branch;
         default: ;
      endcase
      if (head.isn[15:5] == ccop_prefix)
         cls = op_ccop;
   end

   assign pop = fifo_valid && can_issue;

   always_comb
   begin
      push_data.result   = (cls == op_dual || cls == op_single) ? alu_result : '0;
      push_data.new_pc   = (cls == op_branch) ? br_new_pc : '0;
      push_data.latch_pc = (cls == op_branch) && br_take;
      case (cls)
         op_dual, op_single: push_data.new_cc = alu_cc;
         op_ccop:            push_data.new_cc = ccop_cc;
         default:            push_data.new_cc = cc_q;
      endcase
      push_data.latch_cc = (cls == op_dual || cls == op_single || cls == op_ccop);
   end

   // next instruction sees the updated codes
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         cc_q <= '0;
      else if (pop && push_data.latch_cc)
         cc_q <= push_data.new_cc;
   end

endmodule

//--- logic/result_out.sv
// output queue and credit counter
// registers the queue head onto the result ports
module result_out import pdp_exec_pkg::*; #(
   parameter int out_depth = 4
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       push,
   input  res_entry_t push_data,
   input  logic       res_credit,
   output logic       can_issue,
   output logic       res_valid,
   output word_t      res_data,
   output word_t      res_new_pc,
   output logic       res_latch_pc,
   output cc_t        res_cc,
   output logic       res_latch_cc
);
   localparam int cnt_w = $clog2(out_depth + 1);

   res_entry_t       q_head;
   logic             q_valid;
   logic             q_full;
   logic             send;
   logic [cnt_w-1:0] credits;

   credit_fifo #(
      .depth     (out_depth),
      .payload_t (res_entry_t)
   ) out_fifo (
      .clk        (clk),
      .rst_n      (rst_n),
      .push       (push),
      .push_data  (push_data),
      .pop        (send),
      .head       (q_head),
      .fifo_valid (q_valid),
      .full       (q_full)
   );

   assign can_issue = !q_full;
   // one result leaves per held credit
   assign send = q_valid && (credits != '0);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         credits      <= cnt_w'(out_depth);
         res_valid    <= 1'b0;
         res_latch_pc <= 1'b0;
         res_latch_cc <= 1'b0;
      end
      else
      begin
         credits      <= credits - cnt_w'(send) + cnt_w'(res_credit);
         res_valid    <= send;
         res_latch_pc <= send && q_head.latch_pc;
         res_latch_cc <= send && q_head.latch_cc;
      end
   end

   always_ff @(posedge clk)
   begin
      if (send)
      begin
         res_data   <= q_head.result;
         res_new_pc <= q_head.new_pc;
         res_cc     <= q_head.new_cc;
      end
   end

endmodule

//--- logic/exec_top.sv
// execute stage top level
// input queue, execute core and credit-paced output side
module exec_top import pdp_exec_pkg::*; #(
   parameter int in_depth  = 4,
   parameter int out_depth = 4
) (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  isn_valid,
   input  word_t isn,
   input  word_t pc,
   input  word_t ss_data,
   input  word_t dd_data,
   output logic  isn_credit,
   input  logic  res_credit,
   output logic  res_valid,
   output word_t res_data,
   output word_t res_new_pc,
   output logic  res_latch_pc,
   output cc_t   res_cc,
   output logic  res_latch_cc
);
   isn_entry_t in_entry;
   isn_entry_t head;
   logic       fifo_valid;
   logic       pop;
   logic       can_issue;
   res_entry_t push_data;

   assign in_entry   = '{isn: isn, pc: pc, ss_data: ss_data, dd_data: dd_data};
   // each pop frees one input slot
   assign isn_credit = pop;

   credit_fifo #(
      .depth     (in_depth),
      .payload_t (isn_entry_t)
   ) in_fifo (
      .clk        (clk),
      .rst_n      (rst_n),
      .push       (isn_valid),
      .push_data  (in_entry),
      .pop        (pop),
      .head       (head),
      .fifo_valid (fifo_valid),
      .full       ()
   );

   exec_core core (
      .clk        (clk),
      .rst_n      (rst_n),
      .head       (head),
      .fifo_valid (fifo_valid),
      .can_issue  (can_issue),
      .pop        (pop),
      .push_data  (push_data)
   );

   result_out #(
      .out_depth (out_depth)
   ) out_side (
      .clk          (clk),
      .rst_n        (rst_n),
      .push         (pop),
      .push_data    (push_data),
      .res_credit   (res_credit),
      .can_issue    (can_issue),
      .res_valid    (res_valid),
      .res_data     (res_data),
      .res_new_pc   (res_new_pc),
      .res_latch_pc (res_latch_pc),
      .res_cc       (res_cc),
      .res_latch_cc (res_latch_cc)
   );

endmodule

//--- dv/exec_clk_gen.sv
// testbench clock and reset source
// 20 ns clock, rst_n held low for two cycles
module exec_clk_gen (
   output logic clk,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 1ps;

   initial
   begin
      clk = 1'b0;
      forever
         #10 clk = ~clk;
   end

   // released just after the second edge
   initial
   begin
      rst_n = 1'b0;
      repeat (2)
         @(posedge clk);
      #1;
      rst_n = 1'b1;
   end

endmodule

//--- dv/exec_checker.sv
// credit protocol assertions for the top-level ports
// bound into exec_top with running counts of accepted and returned items
module exec_checker #(
   parameter int out_depth = 4
) (
   input logic clk,
   input logic rst_n,
   input logic isn_valid,
   input logic isn_credit,
   input logic res_valid,
   input logic res_credit
);
   timeunit 1ns;
   timeprecision 1ps;

   int unsigned accepted;
   int unsigned freed;
   int unsigned sent;
   int unsigned returned;
   int          fail_count = 0;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         accepted <= 0;
         freed    <= 0;
         sent     <= 0;
         returned <= 0;
      end
      else
      begin
         accepted <= accepted + 32'(isn_valid);
         freed    <= freed + 32'(isn_credit);
         sent     <= sent + 32'(res_valid);
         returned <= returned + 32'(res_credit);
      end
   end

   // a slot is freed only for an instruction already taken in
   a_in_credit: assert property (@(posedge clk) disable iff (!rst_n)
      isn_credit |-> freed < accepted)
   else
   begin
      fail_count = fail_count + 1;
      $error("input credit returned with no instruction outstanding");
   end

   // every result belongs to an instruction already popped
   a_res_popped: assert property (@(posedge clk) disable iff (!rst_n)
      res_valid |-> sent < freed)
   else
   begin
      fail_count = fail_count + 1;
      $error("result sent with no popped instruction behind it");
   end

   a_out_credit: assert property (@(posedge clk) disable iff (!rst_n)
      res_valid |-> (sent - returned) < out_depth)
   else
   begin
      fail_count = fail_count + 1;
      $error("result sent while no output credit was held");
   end

endmodule

//--- dv/exec_tb.sv
// execute stage testbench
// sender and consumer credit models, in-order reference model,
// result scoreboard and cycle timeout
module exec_tb import pdp_exec_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int in_depth  = 4;
   localparam int out_depth = 4;

   localparam logic [3:0] dual_ops [7] = '{opc_mov, opc_cmp, opc_bit, opc_bic,
                                           opc_bis, opc_add, opc_sub};
   localparam logic [9:0] single_ops [10] = '{sop_clr, sop_com, sop_inc, sop_dec, sop_neg,
                                              sop_tst, sop_ror, sop_rol, sop_asr, sop_asl};
   localparam logic [7:0] branch_ops [7] = '{br_br, br_bne, br_beq, br_bpl,
                                             br_bmi, br_bcc, br_bcs};
   // overflow and carry corners as src/dst pairs
   localparam word_t corner_s [4] = '{16'h7fff, 16'h8000, 16'hffff, 16'h8000};
   localparam word_t corner_d [4] = '{16'h0001, 16'h8000, 16'h0001, 16'h7fff};
   localparam word_t single_corners [4] = '{16'h8000, 16'h7fff, 16'h0000, 16'hffff};
   localparam cc_t   cc_masks [4] = '{4'b0000, 4'b1111, 4'b0101, 4'b1010};
   localparam word_t unknown_ops [4] = '{16'o000000, 16'o070000, 16'o106000, 16'o177777};

   logic  clk;
   logic  rst_n;
   logic  isn_valid;
   word_t isn;
   word_t pc;
   word_t ss_data;
   word_t dd_data;
   logic  isn_credit;
   logic  res_credit;
   logic  res_valid;
   word_t res_data;
   word_t res_new_pc;
   logic  res_latch_pc;
   cc_t   res_cc;
   logic  res_latch_cc;

   int         seed = 88;
   word_t      prog_isn [$];
   word_t      prog_pc [$];
   word_t      prog_ss [$];
   word_t      prog_dd [$];
   res_entry_t exp_q [$];
   cc_t        model_cc = '0;
   int         n_isn = 0;
   int         limit = 0;
   int         cycles = 0;
   int         sent_count = 0;
   int         credits_back = 0;
   int         results_seen = 0;
   int         returned = 0;
   int         stall = 0;

   exec_clk_gen clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   exec_top #(
      .in_depth  (in_depth),
      .out_depth (out_depth)
   ) dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .isn_valid    (isn_valid),
      .isn          (isn),
      .pc           (pc),
      .ss_data      (ss_data),
      .dd_data      (dd_data),
      .isn_credit   (isn_credit),
      .res_credit   (res_credit),
      .res_valid    (res_valid),
      .res_data     (res_data),
      .res_new_pc   (res_new_pc),
      .res_latch_pc (res_latch_pc),
      .res_cc       (res_cc),
      .res_latch_cc (res_latch_cc)
   );

   bind exec_top exec_checker #(
      .out_depth (out_depth)
   ) chk (
      .clk        (clk),
      .rst_n      (rst_n),
      .isn_valid  (isn_valid),
      .isn_credit (isn_credit),
      .res_valid  (res_valid),
      .res_credit (res_credit)
   );

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic report_mismatch(input string name, input word_t expected, input word_t got);
      stop_with_failure($sformatf("Mismatch %s exp %h got %h", name, expected, got));
   endtask

   function automatic word_t rnd16();
      return word_t'($random(seed));
   endfunction

   task automatic add_isn(input word_t i, input word_t p, input word_t s, input word_t d);
      prog_isn.push_back(i);
      prog_pc.push_back(p);
      prog_ss.push_back(s);
      prog_dd.push_back(d);
   endtask

   // expected result entry from the instruction rules and the current codes
   function automatic res_entry_t predict(input word_t i, input word_t p, input word_t s,
                                         input word_t d, input cc_t cc_in);
      res_entry_t  e;
      logic [16:0] wide;
      word_t       r;
      word_t       offset;
      logic        v;
      logic        c;
      logic        alu_op;
      logic        is_br;
      logic        take;
      e.result   = '0;
      e.new_pc   = '0;
      e.latch_pc = 1'b0;
      e.new_cc   = cc_in;
      e.latch_cc = 1'b0;
      r      = '0;
      v      = 1'b0;
      c      = cc_in[cc_c_bit];
      alu_op = 1'b1;
      case (1'b1)
         i[15:9] == opc_xor:  r = s ^ d;
         i[15:12] == opc_mov: r = s;
         i[15:12] == opc_bit: r = s & d;
         i[15:12] == opc_bic: r = d & ~s;
         i[15:12] == opc_bis: r = s | d;
         i[15:12] == opc_cmp:
         begin
            wide = {1'b0, s} - {1'b0, d};
            r = wide[15:0];
            v = (s[15] != d[15]) && (r[15] == d[15]);
            c = wide[16];
         end
         i[15:12] == opc_add:
         begin
            wide = {1'b0, s} + {1'b0, d};
            r = wide[15:0];
            v = (s[15] == d[15]) && (r[15] != s[15]);
            c = wide[16];
         end
         i[15:12] == opc_sub:
         begin
            wide = {1'b0, d} - {1'b0, s};
            r = wide[15:0];
            v = (s[15] != d[15]) && (r[15] == s[15]);
            c = wide[16];
         end
         i[15:6] == sop_clr: c = 1'b0;
         i[15:6] == sop_com:
         begin
            r = ~d;
            c = 1'b1;
         end
         i[15:6] == sop_inc:
         begin
            r = d + 16'd1;
            v = (d == 16'h7fff);
         end
         i[15:6] == sop_dec:
         begin
            r = d - 16'd1;
            v = (d == 16'h8000);
         end
         i[15:6] == sop_neg:
         begin
            r = 16'd0 - d;
            v = (d == 16'h8000);
            c = (d != 16'h0000);
         end
         i[15:6] == sop_tst:
         begin
            r = d;
            c = 1'b0;
         end
         i[15:6] == sop_ror:
         begin
            r = {cc_in[cc_c_bit], d[15:1]};
            c = d[0];
            v = r[15] ^ c;
         end
         i[15:6] == sop_rol:
         begin
            r = {d[14:0], cc_in[cc_c_bit]};
            c = d[15];
            v = r[15] ^ c;
         end
         i[15:6] == sop_asr:
         begin
            r = {d[15], d[15:1]};
            c = d[0];
            v = r[15] ^ c;
         end
         i[15:6] == sop_asl:
         begin
            r = {d[14:0], 1'b0};
            c = d[15];
            v = r[15] ^ c;
         end
         default: alu_op = 1'b0;
      endcase

      if (alu_op)
      begin
         e.result   = r;
         e.new_cc   = {r[15], (r == 16'h0000), v, c};
         e.latch_cc = 1'b1;
      end
      else if (i[15:5] == ccop_prefix)
      begin
         e.new_cc   = i[4] ? (cc_in | i[3:0]) : (cc_in & ~i[3:0]);
         e.latch_cc = 1'b1;
      end
      else
      begin
         is_br = 1'b1;
         case (i[15:8])
            br_br:   take = 1'b1;
            br_bne:  take = !cc_in[cc_z_bit];
            br_beq:  take = cc_in[cc_z_bit];
            br_bpl:  take = !cc_in[cc_n_bit];
            br_bmi:  take = cc_in[cc_n_bit];
            br_bcc:  take = !cc_in[cc_c_bit];
            br_bcs:  take = cc_in[cc_c_bit];
            default:
            begin
               is_br = 1'b0;
               take  = 1'b0;
            end
         endcase
         if (is_br)
         begin
            offset     = {{8{i[7]}}, i[7:0]};
            e.new_pc   = p + (offset << 1);
            e.latch_pc = take;
         end
      end
      return e;
   endfunction

   task automatic build_program();
      word_t a;
      word_t b;
      word_t f;
      // op 7 stands for xor
      for (int op = 0; op < 8; op++)
      begin
         for (int k = 0; k < 10; k++)
         begin
            f = rnd16();
            a = (k < 4) ? corner_s[k] : rnd16();
            b = (k < 4) ? corner_d[k] : rnd16();
            if (op == 7)
               add_isn({opc_xor, f[8:0]}, rnd16(), a, b);
            else
               add_isn({dual_ops[op], f[11:0]}, rnd16(), a, b);
         end
      end
      // singles take their carry from the instruction before
      for (int op = 0; op < 10; op++)
      begin
         for (int k = 0; k < 7; k++)
         begin
            f = rnd16();
            a = (k < 4) ? single_corners[k] : rnd16();
            add_isn({single_ops[op], f[5:0]}, rnd16(), rnd16(), a);
         end
      end
      // clear all codes, set a known pattern, then every branch
      for (int m = 0; m < 4; m++)
      begin
         add_isn(16'o000257, rnd16(), rnd16(), rnd16());
         add_isn(16'o000260 | {12'h000, cc_masks[m]}, rnd16(), rnd16(), rnd16());
         for (int br = 0; br < 7; br++)
         begin
            f = rnd16();
            add_isn({branch_ops[br], f[7:0]}, rnd16() & 16'hfffe, rnd16(), rnd16());
         end
         add_isn(unknown_ops[m], rnd16(), rnd16(), rnd16());
      end
      n_isn = prog_isn.size();
   endtask

   task automatic offer_isn(input int idx);
      isn_valid = 1'b1;
      isn       = prog_isn[idx];
      pc        = prog_pc[idx];
      ss_data   = prog_ss[idx];
      dd_data   = prog_dd[idx];
      exp_q.push_back(predict(isn, pc, ss_data, dd_data, model_cc));
      if (exp_q[$].latch_cc)
         model_cc = exp_q[$].new_cc;
      sent_count++;
   endtask

   // consumer frees results one per cycle with random holds
   task automatic return_credit();
      res_credit = 1'b0;
      if (stall > 0)
         stall--;
      else if (results_seen > returned)
      begin
         if ($unsigned($random(seed)) % 6 == 0)
            stall = 3 + ($unsigned($random(seed)) % 16);
         else
         begin
            res_credit = 1'b1;
            returned++;
         end
      end
   endtask

   task automatic check_result();
      res_entry_t exp;
      assert (exp_q.size() != 0)
      else stop_with_failure("result arrived with no instruction outstanding");
      exp = exp_q.pop_front();
      assert (res_data == exp.result)
      else report_mismatch("res_data", exp.result, res_data);
      assert (res_cc == exp.new_cc)
      else report_mismatch("res_cc", word_t'(exp.new_cc), word_t'(res_cc));
      assert (res_latch_cc == exp.latch_cc)
      else report_mismatch("res_latch_cc", word_t'(exp.latch_cc), word_t'(res_latch_cc));
      assert (res_latch_pc == exp.latch_pc)
      else report_mismatch("res_latch_pc", word_t'(exp.latch_pc), word_t'(res_latch_pc));
      assert (res_new_pc == exp.new_pc)
      else report_mismatch("res_new_pc", exp.new_pc, res_new_pc);
      results_seen++;
   endtask

   initial
   begin
      isn_valid  = 1'b0;
      isn        = '0;
      pc         = '0;
      ss_data    = '0;
      dd_data    = '0;
      res_credit = 1'b0;
      build_program();
      limit = n_isn * (in_depth + out_depth + 10) + 100;
      wait (rst_n === 1'b1);
      wait (results_seen == n_isn);
      repeat (4)
         @(posedge clk);
      // every accepted instruction must have returned its input credit
      if (results_seen == sent_count && credits_back == sent_count && exp_q.size() == 0)
      begin
         $display("Simulation completed successfully");
         $finish;
      end
      else
         stop_with_failure("input credits or results differ from the accepted count");
   end

   // sender holds at most in_depth unreturned credits
   initial
   begin
      int idx;
      idx = 0;
      wait (rst_n === 1'b1);
      forever
      begin
         @(posedge clk);
         #1;
         return_credit();
         if (idx < n_isn && (sent_count - credits_back) < in_depth &&
             ($random(seed) & 3) != 0)
         begin
            offer_isn(idx);
            idx++;
         end
         else
            isn_valid = 1'b0;
      end
   end

   always @(negedge clk)
   begin
      if (rst_n)
      begin
         if (isn_credit)
            credits_back++;
         if (res_valid)
            check_result();
      end
      if (dut.chk.fail_count != 0)
         stop_with_failure("a credit protocol assertion fired");
   end

   always @(posedge clk)
   begin
      cycles++;
      if (limit != 0 && cycles > limit)
         stop_with_failure($sformatf("timeout after %0d cycles", cycles));
   end

endmodule

//--- pdp_exec.f
common/pdp_exec_pkg.sv
logic/credit_fifo.sv
execute/word_alu.sv
execute/branch_unit.sv
execute/exec_core.sv
logic/result_out.sv
logic/exec_top.sv
dv/exec_clk_gen.sv
dv/exec_checker.sv
dv/exec_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module exec_tb --Mdir obj_dir -o exec_sim -f pdp_exec.f
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/exec_sim +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
fi

if grep -qx "Simulation completed successfully" "$log"; then
   exit 0
fi
echo "pass message not found in $log"
exit 1
